// ==== hdl/rob_defs.svh ====
// Shared ROB constants; RTL assumes ROB_DEPTH == 2**ROB_IDX_W and a two-wide machine
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

////////////////////////////////////////
// Machine width
////////////////////////////////////////

// Dispatch, completion and retire slots
`define RETIRE_WAY 2

////////////////////////////////////////
// Reorder buffer geometry
////////////////////////////////////////

`define ROB_DEPTH 16
`define ROB_IDX_W 4   // Index wraps naturally at ROB_DEPTH

////////////////////////////////////////
// Architectural constants
////////////////////////////////////////

`define ZERO_REG  5'd31          // Never written at commit
`define HALT_INST 32'h0000_0555  // Stops retirement once committed

`endif

// ==== hdl/isa_pkg.sv ====
// Instruction set types; 64-bit data and NPC, 32 architectural registers, 2-bit error code
package isa_pkg;

  ////////////////////////////////////////
  // Instruction and operand widths
  ////////////////////////////////////////

  typedef logic [31:0] inst_t;   // Raw instruction word
  typedef logic [63:0] addr_t;   // Next PC
  typedef logic [63:0] data_t;   // Result value
  typedef logic [4:0]  areg_t;   // Architectural register index

  ////////////////////////////////////////
  // Processor status at commit
  ////////////////////////////////////////

  // Halt wins over illegal within the same slot
  typedef enum logic [1:0]
  {
    NO_ERROR          = 2'd0,
    HALTED_ON_HALT    = 2'd1,
    HALTED_ON_ILLEGAL = 2'd2
  } err_status_t;

endpackage

// ==== hdl/rob_pkg.sv ====
// Reorder buffer types; sized from rob_defs.svh, credit count holds 0 to ROB_DEPTH
`include "rob_defs.svh"

package rob_pkg;

  ////////////////////////////////////////
  // Entry addressing
  ////////////////////////////////////////

  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;   // Entry index

  // One extra bit so a full ROB is distinct from an empty one
  typedef logic [`ROB_IDX_W:0]   credit_t;

  // 0..2 entries per cycle
  typedef logic [1:0]            retire_cnt_t;

  ////////////////////////////////////////
  // Retire state machine
  ////////////////////////////////////////

  typedef enum logic
  {
    RUNNING = 1'b0,   // Normal in-order retirement
    HALTED  = 1'b1    // After halt or illegal, left only by reset
  } retire_state_t;

endpackage

// ==== hdl/rob_store.sv ====
// ROB entry storage; a completion must never hit an entry in its dispatch cycle
`include "rob_defs.svh"

module rob_store
  import isa_pkg::*, rob_pkg::*;
(
  input  logic                       clock,
  input  logic                       rst,
  input  logic     [`RETIRE_WAY-1:0] alloc_en,
  input  rob_idx_t [`RETIRE_WAY-1:0] alloc_idx,
  input  inst_t    [`RETIRE_WAY-1:0] dispatch_ir,
  input  addr_t    [`RETIRE_WAY-1:0] dispatch_npc,
  input  areg_t    [`RETIRE_WAY-1:0] dispatch_adest,
  input  logic     [`RETIRE_WAY-1:0] dispatch_illegal,
  input  logic     [`RETIRE_WAY-1:0] cdb_valid,
  input  rob_idx_t [`RETIRE_WAY-1:0] cdb_rob_idx,
  input  data_t    [`RETIRE_WAY-1:0] cdb_value,
  input  rob_idx_t                   head_idx,
  output logic     [`RETIRE_WAY-1:0] head_done,
  output logic     [`RETIRE_WAY-1:0] head_illegal,
  output inst_t    [`RETIRE_WAY-1:0] head_ir,
  output addr_t    [`RETIRE_WAY-1:0] head_npc,
  output areg_t    [`RETIRE_WAY-1:0] head_adest,
  output data_t    [`RETIRE_WAY-1:0] head_value
);

  inst_t ir_mem    [`ROB_DEPTH];
  addr_t npc_mem   [`ROB_DEPTH];
  areg_t adest_mem [`ROB_DEPTH];
  data_t value_mem [`ROB_DEPTH];

  logic [`ROB_DEPTH-1:0] done_q;     // Result present or illegal
  logic [`ROB_DEPTH-1:0] illegal_q;

  rob_idx_t [`RETIRE_WAY-1:0] rd_idx;  // head, head+1

  ////////////////////////////////////////
  // Payload write
  ////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    for (int s = 0; s < `RETIRE_WAY; s++)
    begin
      if (cdb_valid[s])
        value_mem[cdb_rob_idx[s]] <= cdb_value[s];
      if (alloc_en[s])
      begin
        ir_mem[alloc_idx[s]]    <= dispatch_ir[s];
        npc_mem[alloc_idx[s]]   <= dispatch_npc[s];
        adest_mem[alloc_idx[s]] <= dispatch_adest[s];
        value_mem[alloc_idx[s]] <= '0;  // Illegal entries commit zero
      end
    end
  end

  // Entry flags; reallocation overwrites the stale done bit
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      done_q    <= '0;
      illegal_q <= '0;
    end
    else
    begin
      for (int s = 0; s < `RETIRE_WAY; s++)
      begin
        if (cdb_valid[s])
          done_q[cdb_rob_idx[s]] <= 1'b1;
      end
      for (int s = 0; s < `RETIRE_WAY; s++)
      begin
        if (alloc_en[s])
        begin
          done_q[alloc_idx[s]]    <= dispatch_illegal[s];  // Illegal is done at once
          illegal_q[alloc_idx[s]] <= dispatch_illegal[s];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Head read ports
  ////////////////////////////////////////

  always_comb
  begin
    for (int s = 0; s < `RETIRE_WAY; s++)
    begin
      rd_idx[s]       = head_idx + rob_idx_t'(s);
      head_done[s]    = done_q[rd_idx[s]];
      head_illegal[s] = illegal_q[rd_idx[s]];
      head_ir[s]      = ir_mem[rd_idx[s]];
      head_npc[s]     = npc_mem[rd_idx[s]];
      head_adest[s]   = adest_mem[rd_idx[s]];
      head_value[s]   = value_mem[rd_idx[s]];
    end
  end

  // Completions only ever target a pending entry
  for (genvar p = 0; p < `RETIRE_WAY; p++)
  begin : g_cdb_chk
    a_cdb_pending: assert property (@(posedge clock) disable iff (rst)
      cdb_valid[p] |-> !done_q[cdb_rob_idx[p]])
      else $error("CDB port %0d hit a done entry %0d", p, cdb_rob_idx[p]);
  end

endmodule

// ==== hdl/rob_ctrl.sv ====
// ROB pointers and retire selection; no internal stall, sender must respect its credits
`include "rob_defs.svh"

module rob_ctrl
  import isa_pkg::*, rob_pkg::*;
(
  input  logic                       clock,
  input  logic                       rst,
  input  logic     [`RETIRE_WAY-1:0] dispatch_valid,
  input  logic     [`RETIRE_WAY-1:0] head_done,
  input  logic     [`RETIRE_WAY-1:0] head_illegal,
  input  inst_t    [`RETIRE_WAY-1:0] head_ir,
  output logic     [`RETIRE_WAY-1:0] alloc_en,
  output rob_idx_t [`RETIRE_WAY-1:0] alloc_idx,
  output rob_idx_t [`RETIRE_WAY-1:0] dispatch_rob_idx,
  output rob_idx_t                   head_idx,
  output logic     [`RETIRE_WAY-1:0] retire_en,
  output retire_cnt_t                credit_return
);

  rob_idx_t      tail_q;
  rob_idx_t      head_q;
  credit_t       count_q;     // Occupied entries
  retire_state_t state_q;

  retire_cnt_t disp_cnt;
  retire_cnt_t ret_cnt;

  logic [`RETIRE_WAY-1:0] head_stop;  // Halt or illegal at this slot
  logic                   stop_now;   // A stopping instruction retires this cycle

  ////////////////////////////////////////
  // Dispatch allocation
  ////////////////////////////////////////

  always_comb
  begin
    for (int s = 0; s < `RETIRE_WAY; s++)
    begin
      alloc_en[s]  = dispatch_valid[s];
      alloc_idx[s] = tail_q + rob_idx_t'(s);
    end
  end

  assign dispatch_rob_idx = alloc_idx;
  assign disp_cnt = retire_cnt_t'(dispatch_valid[0]) + retire_cnt_t'(dispatch_valid[1]);

  ////////////////////////////////////////
  // In-order retire selection
  ////////////////////////////////////////

  always_comb
  begin
    for (int s = 0; s < `RETIRE_WAY; s++)
      head_stop[s] = head_illegal[s] || (head_ir[s] == `HALT_INST);

    // Stale done bits of free entries are masked by the occupancy
    retire_en[0] = (state_q == RUNNING) && (count_q != '0) && head_done[0];
    retire_en[1] = retire_en[0] && (count_q > credit_t'(1)) && head_done[1]
                   && !head_stop[0];
  end

  assign ret_cnt  = retire_cnt_t'(retire_en[0]) + retire_cnt_t'(retire_en[1]);
  assign stop_now = |(retire_en & head_stop);
  assign head_idx = head_q;

  ////////////////////////////////////////
  // State update
  ////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      tail_q        <= '0;
      head_q        <= '0;
      count_q       <= '0;
      state_q       <= RUNNING;
      credit_return <= '0;
    end
    else
    begin
      tail_q        <= tail_q + rob_idx_t'(disp_cnt);
      head_q        <= head_q + rob_idx_t'(ret_cnt);
      count_q       <= count_q + credit_t'(disp_cnt) - credit_t'(ret_cnt);
      credit_return <= ret_cnt;   // Lines up with commit_valid
      if (stop_now)
        state_q <= HALTED;        // Sticky until reset
    end
  end

  ////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////

  a_occupancy: assert property (@(posedge clock) disable iff (rst)
    count_q <= credit_t'(`ROB_DEPTH))
    else $error("ROB occupancy %0d exceeds depth", count_q);

  a_slot_order: assert property (@(posedge clock) disable iff (rst)
    dispatch_valid[1] |-> dispatch_valid[0])
    else $error("Dispatch slot 1 valid without slot 0");

endmodule

// ==== hdl/retire_status.sv ====
// Registered commit records; error status is sticky and only cleared by reset
`include "rob_defs.svh"

module retire_status
  import isa_pkg::*, rob_pkg::*;
(
  input  logic                    clock,
  input  logic                    rst,
  input  logic  [`RETIRE_WAY-1:0] retire_en,
  input  inst_t [`RETIRE_WAY-1:0] head_ir,
  input  addr_t [`RETIRE_WAY-1:0] head_npc,
  input  areg_t [`RETIRE_WAY-1:0] head_adest,
  input  data_t [`RETIRE_WAY-1:0] head_value,
  input  logic  [`RETIRE_WAY-1:0] head_illegal,
  output logic  [`RETIRE_WAY-1:0] commit_valid,
  output logic  [`RETIRE_WAY-1:0] commit_wr_en,
  output areg_t [`RETIRE_WAY-1:0] commit_wr_idx,
  output data_t [`RETIRE_WAY-1:0] commit_wr_data,
  output addr_t [`RETIRE_WAY-1:0] commit_npc,
  output inst_t [`RETIRE_WAY-1:0] commit_ir,
  output retire_cnt_t             completed_insts,
  output err_status_t             error_status
);

  logic [`RETIRE_WAY-1:0] wr_en_d;
  logic [`RETIRE_WAY-1:0] head_halt;
  retire_cnt_t            done_cnt;
  err_status_t            status_d;

  always_comb
  begin
    for (int s = 0; s < `RETIRE_WAY; s++)
    begin
      head_halt[s] = head_ir[s] == `HALT_INST;
      wr_en_d[s]   = retire_en[s] && !head_illegal[s] && (head_adest[s] != `ZERO_REG);
    end

    // An illegal slot and everything after it do not count
    done_cnt = '0;
    if (retire_en[0] && !head_illegal[0])
    begin
      done_cnt = retire_cnt_t'(1);
      if (retire_en[1] && !head_illegal[1])
        done_cnt = retire_cnt_t'(2);
    end

    // Slot 0 before slot 1, halt before illegal
    if (retire_en[0] && head_halt[0])
      status_d = HALTED_ON_HALT;
    else if (retire_en[0] && head_illegal[0])
      status_d = HALTED_ON_ILLEGAL;
    else if (retire_en[1] && head_halt[1])
      status_d = HALTED_ON_HALT;
    else if (retire_en[1] && head_illegal[1])
      status_d = HALTED_ON_ILLEGAL;
    else
      status_d = NO_ERROR;
  end

  ////////////////////////////////////////
  // Commit registers
  ////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      commit_valid    <= '0;
      commit_wr_en    <= '0;
      completed_insts <= '0;
      error_status    <= NO_ERROR;
    end
    else
    begin
      commit_valid    <= retire_en;
      commit_wr_en    <= wr_en_d;
      completed_insts <= done_cnt;
      if (error_status == NO_ERROR)
        error_status <= status_d;   // First stop wins
    end
  end

  // Record fields hold their last retired value
  always_ff @(posedge clock)
  begin
    for (int s = 0; s < `RETIRE_WAY; s++)
    begin
      if (retire_en[s])
      begin
        commit_wr_idx[s]  <= head_adest[s];
        commit_wr_data[s] <= head_value[s];
        commit_npc[s]     <= head_npc[s];
        commit_ir[s]      <= head_ir[s];
      end
    end
  end

endmodule

// ==== hdl/rob_top.sv ====
// ROB and commit path top; results live in the entries, no register file behind it
`include "rob_defs.svh"

module rob_top
  import isa_pkg::*, rob_pkg::*;
(
  input  logic                       clock,
  input  logic                       rst,
  // Dispatch
  input  logic     [`RETIRE_WAY-1:0] dispatch_valid,
  input  inst_t    [`RETIRE_WAY-1:0] dispatch_ir,
  input  addr_t    [`RETIRE_WAY-1:0] dispatch_npc,
  input  areg_t    [`RETIRE_WAY-1:0] dispatch_adest,
  input  logic     [`RETIRE_WAY-1:0] dispatch_illegal,
  output rob_idx_t [`RETIRE_WAY-1:0] dispatch_rob_idx,
  output retire_cnt_t                credit_return,
  // Completion
  input  logic     [`RETIRE_WAY-1:0] cdb_valid,
  input  rob_idx_t [`RETIRE_WAY-1:0] cdb_rob_idx,
  input  data_t    [`RETIRE_WAY-1:0] cdb_value,
  // Commit
  output logic     [`RETIRE_WAY-1:0] commit_valid,
  output logic     [`RETIRE_WAY-1:0] commit_wr_en,
  output areg_t    [`RETIRE_WAY-1:0] commit_wr_idx,
  output data_t    [`RETIRE_WAY-1:0] commit_wr_data,
  output addr_t    [`RETIRE_WAY-1:0] commit_npc,
  output inst_t    [`RETIRE_WAY-1:0] commit_ir,
  output retire_cnt_t                completed_insts,
  output err_status_t                error_status
);

  logic     [`RETIRE_WAY-1:0] alloc_en;
  rob_idx_t [`RETIRE_WAY-1:0] alloc_idx;
  rob_idx_t                   head_idx;
  logic     [`RETIRE_WAY-1:0] retire_en;

  // Head entry read records
  logic     [`RETIRE_WAY-1:0] head_done;
  logic     [`RETIRE_WAY-1:0] head_illegal;
  inst_t    [`RETIRE_WAY-1:0] head_ir;
  addr_t    [`RETIRE_WAY-1:0] head_npc;
  areg_t    [`RETIRE_WAY-1:0] head_adest;
  data_t    [`RETIRE_WAY-1:0] head_value;

  rob_store i_rob_store (
    .clock            (clock),
    .rst              (rst),
    .alloc_en         (alloc_en),
    .alloc_idx        (alloc_idx),
    .dispatch_ir      (dispatch_ir),
    .dispatch_npc     (dispatch_npc),
    .dispatch_adest   (dispatch_adest),
    .dispatch_illegal (dispatch_illegal),
    .cdb_valid        (cdb_valid),
    .cdb_rob_idx      (cdb_rob_idx),
    .cdb_value        (cdb_value),
    .head_idx         (head_idx),
    .head_done        (head_done),
    .head_illegal     (head_illegal),
    .head_ir          (head_ir),
    .head_npc         (head_npc),
    .head_adest       (head_adest),
    .head_value       (head_value)
  );

  rob_ctrl i_rob_ctrl (
    .clock            (clock),
    .rst              (rst),
    .dispatch_valid   (dispatch_valid),
    .head_done        (head_done),
    .head_illegal     (head_illegal),
    .head_ir          (head_ir),
    .alloc_en         (alloc_en),
    .alloc_idx        (alloc_idx),
    .dispatch_rob_idx (dispatch_rob_idx),
    .head_idx         (head_idx),
    .retire_en        (retire_en),
    .credit_return    (credit_return)
  );

  retire_status i_retire_status (
    .clock            (clock),
    .rst              (rst),
    .retire_en        (retire_en),
    .head_ir          (head_ir),
    .head_npc         (head_npc),
    .head_adest       (head_adest),
    .head_value       (head_value),
    .head_illegal     (head_illegal),
    .commit_valid     (commit_valid),
    .commit_wr_en     (commit_wr_en),
    .commit_wr_idx    (commit_wr_idx),
    .commit_wr_data   (commit_wr_data),
    .commit_npc       (commit_npc),
    .commit_ir        (commit_ir),
    .completed_insts  (completed_insts),
    .error_status     (error_status)
  );

endmodule

// ==== verif/rob_model.svh ====
// ROB reference model; included inside rob_tb after its package imports, mirrors one DUT cycle per call
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// Entry state, indexed like the DUT
inst_t       m_ir      [`ROB_DEPTH];
addr_t       m_npc     [`ROB_DEPTH];
areg_t       m_adest   [`ROB_DEPTH];
data_t       m_value   [`ROB_DEPTH];
bit          m_done    [`ROB_DEPTH];
bit          m_illegal [`ROB_DEPTH];
rob_idx_t    m_head;
rob_idx_t    m_tail;
int          m_count;
int          m_retired;   // Since last reset
bit          m_halted;
err_status_t m_status;

// Commit outputs expected after the next rising edge
bit          exp_valid   [`RETIRE_WAY];
bit          exp_wr_en   [`RETIRE_WAY];
bit          exp_illegal [`RETIRE_WAY];
inst_t       exp_ir      [`RETIRE_WAY];
addr_t       exp_npc     [`RETIRE_WAY];
areg_t       exp_idx     [`RETIRE_WAY];
data_t       exp_data    [`RETIRE_WAY];
retire_cnt_t exp_done_cnt;
retire_cnt_t exp_credit;

function automatic void model_reset();
  m_head = '0;
  m_tail = '0;
  m_count = 0;
  m_retired = 0;
  m_halted = 1'b0;
  m_status = NO_ERROR;
  for (int i = 0; i < `ROB_DEPTH; i++)
  begin
    m_done[i] = 1'b0;
    m_illegal[i] = 1'b0;
  end
  for (int s = 0; s < `RETIRE_WAY; s++)
  begin
    exp_valid[s] = 1'b0;
    exp_wr_en[s] = 1'b0;
  end
  exp_done_cnt = '0;
  exp_credit = '0;
endfunction

function automatic rob_idx_t model_dispatch(inst_t ir, addr_t npc, areg_t adest, bit illegal);
  rob_idx_t idx;
  idx = m_tail;
  m_ir[idx] = ir;
  m_npc[idx] = npc;
  m_adest[idx] = adest;
  m_value[idx] = '0;
  m_done[idx] = illegal;      // Illegal needs no result
  m_illegal[idx] = illegal;
  m_tail = m_tail + rob_idx_t'(1);
  m_count++;
  return idx;
endfunction

function automatic void model_complete(rob_idx_t idx, data_t value);
  m_value[idx] = value;
  m_done[idx] = 1'b1;
endfunction

////////////////////////////////////////
// In-order retirement of one cycle
////////////////////////////////////////

function automatic void model_retire();
  rob_idx_t idx;
  bit       stop;
  bit       halt;
  stop = m_halted;
  exp_done_cnt = '0;
  exp_credit = '0;
  for (int s = 0; s < `RETIRE_WAY; s++)
  begin
    idx = m_head;
    exp_valid[s] = !stop && (m_count > 0) && m_done[idx];
    exp_wr_en[s] = 1'b0;
    if (exp_valid[s])
    begin
      halt = (m_ir[idx] == `HALT_INST);
      exp_ir[s] = m_ir[idx];
      exp_npc[s] = m_npc[idx];
      exp_idx[s] = m_adest[idx];
      exp_data[s] = m_value[idx];
      exp_illegal[s] = m_illegal[idx];
      exp_wr_en[s] = !m_illegal[idx] && (m_adest[idx] != `ZERO_REG);
      exp_credit = exp_credit + retire_cnt_t'(1);
      if (!m_illegal[idx])
        exp_done_cnt = exp_done_cnt + retire_cnt_t'(1);
      if (m_status == NO_ERROR && halt)
        m_status = HALTED_ON_HALT;     // Halt wins within a slot
      else if (m_status == NO_ERROR && m_illegal[idx])
        m_status = HALTED_ON_ILLEGAL;
      if (halt || m_illegal[idx])
      begin
        stop = 1'b1;
        m_halted = 1'b1;
      end
      m_head = m_head + rob_idx_t'(1);
      m_count--;
      m_retired++;
    end
    else
      stop = 1'b1;   // Younger slot waits for the older one
  end
endfunction

`endif

// ==== verif/rob_tb.sv ====
// ROB testbench; random run ending in a halt, then a reset and a run with illegal entries
`include "rob_defs.svh"

module rob_tb
  import isa_pkg::*, rob_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_MAIN       = 400;  // Instructions in the halt run
  localparam int NUM_ILLEGAL    = 80;   // Upper bound for the illegal run
  localparam int DRAIN_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = (NUM_MAIN + NUM_ILLEGAL) * 20;

  logic                       clock = 1'b0;
  logic                       rst;
  logic     [`RETIRE_WAY-1:0] dispatch_valid;
  inst_t    [`RETIRE_WAY-1:0] dispatch_ir;
  addr_t    [`RETIRE_WAY-1:0] dispatch_npc;
  areg_t    [`RETIRE_WAY-1:0] dispatch_adest;
  logic     [`RETIRE_WAY-1:0] dispatch_illegal;
  rob_idx_t [`RETIRE_WAY-1:0] dispatch_rob_idx;
  retire_cnt_t                credit_return;
  logic     [`RETIRE_WAY-1:0] cdb_valid;
  rob_idx_t [`RETIRE_WAY-1:0] cdb_rob_idx;
  data_t    [`RETIRE_WAY-1:0] cdb_value;
  logic     [`RETIRE_WAY-1:0] commit_valid;
  logic     [`RETIRE_WAY-1:0] commit_wr_en;
  areg_t    [`RETIRE_WAY-1:0] commit_wr_idx;
  data_t    [`RETIRE_WAY-1:0] commit_wr_data;
  addr_t    [`RETIRE_WAY-1:0] commit_npc;
  inst_t    [`RETIRE_WAY-1:0] commit_ir;
  retire_cnt_t                completed_insts;
  err_status_t                error_status;

  integer seed;
  int     credits;        // Sender side
  int     returned;       // Sum of credit_return since reset
  int     dispatched;
  int     cycle_cnt = 0;
  bit     seen_illegal;
  addr_t  next_npc;

  `include "rob_model.svh"

  rob_top i_rob_top (
    .clock            (clock),
    .rst              (rst),
    .dispatch_valid   (dispatch_valid),
    .dispatch_ir      (dispatch_ir),
    .dispatch_npc     (dispatch_npc),
    .dispatch_adest   (dispatch_adest),
    .dispatch_illegal (dispatch_illegal),
    .dispatch_rob_idx (dispatch_rob_idx),
    .credit_return    (credit_return),
    .cdb_valid        (cdb_valid),
    .cdb_rob_idx      (cdb_rob_idx),
    .cdb_value        (cdb_value),
    .commit_valid     (commit_valid),
    .commit_wr_en     (commit_wr_en),
    .commit_wr_idx    (commit_wr_idx),
    .commit_wr_data   (commit_wr_data),
    .commit_npc       (commit_npc),
    .commit_ir        (commit_ir),
    .completed_insts  (completed_insts),
    .error_status     (error_status)
  );

  always #5 clock = ~clock;

  always @(posedge clock)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES)
      fail_run($sformatf("Timeout: test still running after %0d cycles", TIMEOUT_CYCLES));
  end

  ////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_commit(input int slot, input bit valid, input bit wr_en, input bit illegal,
                              input inst_t ir, input addr_t npc, input areg_t idx,
                              input data_t data);
    if (commit_valid[slot] !== valid || commit_wr_en[slot] !== wr_en)
      fail_run($sformatf("CHECK FAILED at %0t: slot %0d valid/wr_en %b/%b, expected %b/%b",
                         $time, slot, commit_valid[slot], commit_wr_en[slot], valid, wr_en));
    if (valid && (commit_ir[slot] !== ir || commit_npc[slot] !== npc))
      fail_run($sformatf("CHECK FAILED at %0t: slot %0d ir/npc %h/%h, expected %h/%h",
                         $time, slot, commit_ir[slot], commit_npc[slot], ir, npc));
    if (valid && commit_wr_idx[slot] !== idx)
      fail_run($sformatf("CHECK FAILED at %0t: slot %0d wr_idx %0d, expected %0d",
                         $time, slot, commit_wr_idx[slot], idx));
    if (valid && !illegal && commit_wr_data[slot] !== data)   // Illegal has no result
      fail_run($sformatf("CHECK FAILED at %0t: slot %0d wr_data %h, expected %h",
                         $time, slot, commit_wr_data[slot], data));
  endtask

  task automatic check_count(input string what, input retire_cnt_t exp, input retire_cnt_t act);
    if (act !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, act, exp));
  endtask

  task automatic check_status(input err_status_t exp);
    if (error_status !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: error_status %0d, expected %0d",
                         $time, error_status, exp));
  endtask

  task automatic check_index(input int slot, input rob_idx_t exp, input rob_idx_t act);
    if (act !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: slot %0d dispatch_rob_idx %0d, expected %0d",
                         $time, slot, act, exp));
  endtask

  task automatic compare_outputs();
    for (int s = 0; s < `RETIRE_WAY; s++)
      check_commit(s, exp_valid[s], exp_wr_en[s], exp_illegal[s], exp_ir[s], exp_npc[s],
                   exp_idx[s], exp_data[s]);
    check_count("completed_insts", exp_done_cnt, completed_insts);
    check_count("credit_return", exp_credit, credit_return);
    check_status(m_status);
  endtask

  task automatic check_totals();
    if (returned != m_retired)
      fail_run($sformatf("CHECK FAILED at %0t: %0d credits returned, %0d retired",
                         $time, returned, m_retired));
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic drive_idle();
    dispatch_valid = '0;
    dispatch_ir = '0;
    dispatch_npc = '0;
    dispatch_adest = '0;
    dispatch_illegal = '0;
    cdb_valid = '0;
    cdb_rob_idx = '0;
    cdb_value = '0;
  endtask

  // Random pending entries, never one dispatched this cycle
  task automatic drive_completions();
    rob_idx_t    pend [$];
    rob_idx_t    idx;
    int          k;
    logic [31:0] hi;
    logic [31:0] lo;
    for (int pos = 0; pos < m_count; pos++)
    begin
      idx = m_head + rob_idx_t'(pos);
      if (!m_done[idx])
        pend.push_back(idx);
    end
    for (int p = 0; p < `RETIRE_WAY; p++)
    begin
      cdb_valid[p] = 1'b0;
      if (pend.size() > 0 && ($random(seed) & 3) != 0)
      begin
        k = ($random(seed) & 32'h7fff_ffff) % pend.size();
        idx = pend[k];
        pend.delete(k);
        hi = $random(seed);
        lo = $random(seed);
        cdb_valid[p] = 1'b1;
        cdb_rob_idx[p] = idx;
        cdb_value[p] = {hi, lo};
        model_complete(idx, {hi, lo});
      end
    end
  endtask

  task automatic drive_dispatch(input int target, input bit illegal_on, input int halt_at);
    int       n;
    int       r;
    inst_t    ir;
    areg_t    adest;
    bit       ill;
    rob_idx_t idx;
    n = ($random(seed) & 32'h7fff_ffff) % 3;
    if (n > credits)
      n = credits;                     // Only within credits
    if (n > target - dispatched)
      n = target - dispatched;
    for (int s = 0; s < `RETIRE_WAY; s++)
    begin
      dispatch_valid[s] = 1'b0;
      dispatch_illegal[s] = 1'b0;
      if (s < n)
      begin
        ir = $random(seed);
        if (ir == `HALT_INST)
          ir = ir ^ 32'h1;
        if (dispatched == halt_at)
          ir = `HALT_INST;
        r = $random(seed);
        adest = ((r & 7) == 0) ? `ZERO_REG : areg_t'(r >> 3);
        ill = illegal_on && (($random(seed) & 15) == 0);
        if (illegal_on && !seen_illegal && dispatched == target - 1)
          ill = 1'b1;                  // At least one per illegal run
        seen_illegal |= ill;
        idx = model_dispatch(ir, next_npc, adest, ill);
        check_index(s, idx, dispatch_rob_idx[s]);
        dispatch_valid[s] = 1'b1;
        dispatch_ir[s] = ir;
        dispatch_npc[s] = next_npc;
        dispatch_adest[s] = adest;
        dispatch_illegal[s] = ill;
        next_npc = next_npc + 64'd4;
        credits--;
        dispatched++;
      end
    end
  endtask

  // Outputs are registered, so they are stable at the falling edge
  task automatic run_cycle(input int target, input bit illegal_on, input int halt_at);
    @(negedge clock);
    compare_outputs();
    credits = credits + int'(credit_return);
    returned = returned + int'(credit_return);
    model_retire();
    drive_completions();
    drive_dispatch(target, illegal_on, halt_at);
  endtask

  function automatic bit phase_done(input int target);
    return (dispatched == target || (m_halted && credits == 0)) && (m_halted || m_count == 0);
  endfunction

  task automatic run_phase(input int target, input bit illegal_on, input int halt_at);
    while (!phase_done(target))
      run_cycle(target, illegal_on, halt_at);
    repeat (DRAIN_CYCLES) run_cycle(target, illegal_on, halt_at);  // Nothing after the stop
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    drive_idle();
    model_reset();
    credits = `ROB_DEPTH;
    returned = 0;
    dispatched = 0;
    seen_illegal = 1'b0;
    repeat (10) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    seed = 32'h1fe2_face;
    next_npc = 64'h1000;
    apply_reset();
    run_phase(NUM_MAIN, 1'b0, NUM_MAIN - 6);   // Halt near the end
    if (dispatched != NUM_MAIN)
      fail_run("Sender ran out of credits before the halt run was dispatched");
    check_status(HALTED_ON_HALT);
    check_totals();
    $display("Halt run: %0d dispatched, %0d retired", dispatched, m_retired);
    apply_reset();
    run_phase(NUM_ILLEGAL, 1'b1, -1);
    check_status(HALTED_ON_ILLEGAL);
    check_totals();
    $display("Illegal run: %0d dispatched, %0d retired", dispatched, m_retired);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+hdl
+incdir+verif
hdl/isa_pkg.sv
hdl/rob_pkg.sv
hdl/rob_store.sv
hdl/rob_ctrl.sv
hdl/retire_status.sv
hdl/rob_top.sv
verif/rob_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := rob_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
